// ==== verilog/load_pkg.sv ====
/* load opcodes, load request, pending-load and result structs,
   data and id widths, transfer-size helper */

`default_nettype none

package load_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned XLEN       = 64;
    localparam int unsigned VADDR_W    = 39;
    localparam int unsigned PADDR_W    = 56;
    localparam int unsigned TRANS_ID_W = 3;
    localparam int unsigned PAGE_OFF_W = 12;

    // integer loads only, the order has no meaning for the hardware
    typedef enum logic [2:0] {
        LB, LBU, LH, LHU, LW, LWU, LD
    } load_op_e;

    // request as it comes from issue
    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [VADDR_W-1:0]    vaddr;
        load_op_e              op;
        logic [7:0]            be;
    } load_req_t;

    // what has to be remembered between the grant and the read data
    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [2:0]            offset;
        load_op_e              op;
    } load_meta_t;

    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN-1:0]       result;
    } load_result_t;

    // cache transfer size: byte 0, half 1, word 2, double 3
    function automatic logic [1:0] transfer_size(input load_op_e op);
        case (op)
            LB, LBU: return 2'd0;
            LH, LHU: return 2'd1;
            LW, LWU: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
/* data cache port widths, cache request and cache response structs */

`default_nettype none

package dcache_pkg;

    // ------------------------------
    // port widths
    // ------------------------------
    // the index is the untranslated page offset, so it can go out before the TLB answers
    localparam int unsigned INDEX_W = 12;
    // the rest of the physical address is sent one cycle later as the tag
    localparam int unsigned TAG_W   = load_pkg::PADDR_W - INDEX_W;
    localparam int unsigned DATA_W  = load_pkg::XLEN;
    localparam int unsigned BE_W    = DATA_W / 8;

    // load unit to cache, read only so no write data travels here
    typedef struct packed {
        logic [INDEX_W-1:0] address_index;
        logic [TAG_W-1:0]   address_tag;
        logic               data_req;
        logic [BE_W-1:0]    data_be;
        logic [1:0]         data_size;
        // tag phase, kill_req is only looked at together with tag_valid
        logic               tag_valid;
        logic               kill_req;
    } dcache_req_t;

    // cache to load unit
    typedef struct packed {
        logic              data_gnt;
        logic              data_rvalid;
        logic [DATA_W-1:0] data_rdata;
    } dcache_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/load_fsm.sv ====
/* load request FSM: translation request, cache index and tag phases,
   TLB miss abort and retry, flush kill and read-valid drop */

`timescale 1ns/1ns
`default_nettype none

module load_fsm (
    input  wire logic                             clk_i,
    input  wire logic                             rst_ni,
    input  wire logic                             flush_i,
    // issue side
    input  wire logic                             valid_i,
    input  wire load_pkg::load_req_t              req_i,
    output logic                                  pop_o,
    // address translation
    output logic                                  translation_req_o,
    output logic [load_pkg::VADDR_W-1:0]          vaddr_o,
    output logic [load_pkg::PAGE_OFF_W-1:0]       page_offset_o,
    input  wire logic [load_pkg::PADDR_W-1:0]     paddr_i,
    input  wire logic                             dtlb_hit_i,
    input  wire logic                             page_offset_match_i,
    // data cache
    output dcache_pkg::dcache_req_t               dcache_req_o,
    input  wire logic                             data_gnt_i,
    input  wire logic                             data_rvalid_i,
    output logic                                  drop_rvalid_o
);

    typedef enum logic [2:0] {
        IDLE, WAIT_PAGE_OFFSET, WAIT_GNT, SEND_TAG, ABORT, WAIT_TRANSLATION, WAIT_FLUSH
    } state_e;

    state_e                         state_d, state_q;
    logic [dcache_pkg::TAG_W-1:0]   tag_q;

    // the address goes straight to the TLB and the store address checker
    assign vaddr_o       = req_i.vaddr;
    assign page_offset_o = req_i.vaddr[load_pkg::PAGE_OFF_W-1:0];

    // ------------------------------
    // request control
    // ------------------------------
    always_comb begin
        state_d                    = state_q;
        pop_o                      = 1'b0;
        translation_req_o          = 1'b0;
        dcache_req_o.address_index = req_i.vaddr[dcache_pkg::INDEX_W-1:0];
        dcache_req_o.address_tag   = tag_q;
        dcache_req_o.data_req      = 1'b0;
        dcache_req_o.data_be       = req_i.be;
        dcache_req_o.data_size     = load_pkg::transfer_size(req_i.op);
        dcache_req_o.tag_valid     = 1'b0;
        dcache_req_o.kill_req      = 1'b0;

        case (state_q)
            // index was granted with a TLB hit last cycle, now the tag goes out
            SEND_TAG: begin
                dcache_req_o.tag_valid = 1'b1;
                state_d                = IDLE;
            end
            // a store to the same page offset is still around, nothing is requested
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // hold both requests up until the cache takes the index
            WAIT_GNT: begin
                translation_req_o     = 1'b1;
                dcache_req_o.data_req = 1'b1;
                if (data_gnt_i) begin
                    if (dtlb_hit_i) begin
                        pop_o   = 1'b1;
                        state_d = SEND_TAG;
                    end else begin
                        state_d = ABORT;
                    end
                end
            end
            // the index was granted but there is no translation, so the cache slot is freed
            ABORT: begin
                dcache_req_o.kill_req  = 1'b1;
                dcache_req_o.tag_valid = 1'b1;
                state_d                = WAIT_TRANSLATION;
            end
            // keep asking the TLB until the walk has filled it
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // one cycle that cancels whatever is sitting in the tag phase
            WAIT_FLUSH: begin
                dcache_req_o.kill_req  = 1'b1;
                dcache_req_o.tag_valid = 1'b1;
                state_d                = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // a new load may start from IDLE and also from SEND_TAG, which gives back-to-back loads
        if ((state_q == IDLE || state_q == SEND_TAG) && valid_i) begin
            // translation starts at once even if the page offset still matches a store
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                dcache_req_o.data_req = 1'b1;
                if (!data_gnt_i) begin
                    state_d = WAIT_GNT;
                end else if (dtlb_hit_i) begin
                    pop_o   = 1'b1;
                    state_d = SEND_TAG;
                end else begin
                    state_d = ABORT;
                end
            end
        end

        // flush wins over everything and the load that would pop here stays with issue
        if (flush_i) begin
            pop_o   = 1'b0;
            state_d = WAIT_FLUSH;
        end
    end

    // read data in a kill cycle, which includes WAIT_FLUSH, belongs to a cancelled request
    assign drop_rvalid_o = data_rvalid_i && dcache_req_o.kill_req;

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the translation belongs to the popped load while req_i may already show the next one
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            tag_q <= paddr_i[dcache_pkg::TAG_W+dcache_pkg::INDEX_W-1:dcache_pkg::INDEX_W];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_realign.sv ====
/* pending-load register, early sign-bit selection and the
   shift and extend result mux */

`timescale 1ns/1ns
`default_nettype none

module load_realign (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         pop_i,
    input  wire load_pkg::load_meta_t         meta_i,
    input  wire logic                         rvalid_i,
    input  wire logic                         drop_i,
    input  wire logic [load_pkg::XLEN-1:0]    rdata_i,
    output logic                              valid_o,
    output load_pkg::load_result_t            result_o
);

    load_pkg::load_meta_t           meta_q;
    logic                           signed_d, signed_q;
    logic [2:0]                     idx_d, idx_q;
    logic [load_pkg::XLEN-1:0]      shifted;
    logic [7:0]                     sign_bits;
    logic                           sign_bit;

    // ------------------------------
    // pending load
    // ------------------------------
    // signedness and sign byte are known at the grant, so they are settled a cycle early
    assign signed_d = meta_i.op inside {load_pkg::LB, load_pkg::LH, load_pkg::LW};
    // the sign sits in the top byte of the loaded item, counted from the offset
    assign idx_d = (meta_i.op == load_pkg::LW) ? meta_i.offset + 3'd3 :
                   (meta_i.op == load_pkg::LH) ? meta_i.offset + 3'd1 :
                                                 meta_i.offset;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            meta_q   <= '0;
            signed_q <= 1'b0;
            idx_q    <= '0;
        end else if (pop_i) begin
            meta_q   <= meta_i;
            signed_q <= signed_d;
            idx_q    <= idx_d;
        end
    end

    // ------------------------------
    // realign and extend
    // ------------------------------
    assign shifted = rdata_i >> {meta_q.offset, 3'b000};

    // top bit of every byte lane, picked in parallel to the shifter
    assign sign_bits = {rdata_i[63], rdata_i[55], rdata_i[47], rdata_i[39],
                        rdata_i[31], rdata_i[23], rdata_i[15], rdata_i[7]};
    // unsigned loads pull the fill to zero
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin
        result_o.trans_id = meta_q.trans_id;
        case (meta_q.op)
            load_pkg::LW, load_pkg::LWU: begin
                result_o.result = {{(load_pkg::XLEN-32){sign_bit}}, shifted[31:0]};
            end
            load_pkg::LH, load_pkg::LHU: begin
                result_o.result = {{(load_pkg::XLEN-16){sign_bit}}, shifted[15:0]};
            end
            load_pkg::LB, load_pkg::LBU: begin
                result_o.result = {{(load_pkg::XLEN-8){sign_bit}}, shifted[7:0]};
            end
            default: begin
                result_o.result = shifted;
            end
        endcase
    end

    // no back-pressure, a result is only ever suppressed for killed data
    assign valid_o = rvalid_i && !drop_i;

endmodule

`default_nettype wire

// ==== verilog/load_unit.sv ====
/* load unit top: request FSM and realign path */

`timescale 1ns/1ns
`default_nettype none

module load_unit (
    input  wire logic                             clk_i,
    input  wire logic                             rst_ni,
    input  wire logic                             flush_i,
    // issue side
    input  wire logic                             valid_i,
    input  wire load_pkg::load_req_t              req_i,
    output logic                                  pop_o,
    // address translation
    output logic                                  translation_req_o,
    output logic [load_pkg::VADDR_W-1:0]          vaddr_o,
    input  wire logic [load_pkg::PADDR_W-1:0]     paddr_i,
    input  wire logic                             dtlb_hit_i,
    // store address checker
    output logic [load_pkg::PAGE_OFF_W-1:0]       page_offset_o,
    input  wire logic                             page_offset_match_i,
    // data cache
    output dcache_pkg::dcache_req_t               dcache_req_o,
    input  wire dcache_pkg::dcache_rsp_t          dcache_rsp_i,
    // result side
    output logic                                  valid_o,
    output load_pkg::load_result_t                result_o
);

    load_pkg::load_meta_t   meta;
    logic                   drop_rvalid;

    // ------------------------------
    // pending-load record
    // ------------------------------
    // only the byte offset within the double word is needed for the realign
    assign meta.trans_id = req_i.trans_id;
    assign meta.offset   = req_i.vaddr[2:0];
    assign meta.op       = req_i.op;

    load_fsm i_load_fsm (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .req_i               (req_i),
        .pop_o               (pop_o),
        .translation_req_o   (translation_req_o),
        .vaddr_o             (vaddr_o),
        .page_offset_o       (page_offset_o),
        .paddr_i             (paddr_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .page_offset_match_i (page_offset_match_i),
        .dcache_req_o        (dcache_req_o),
        .data_gnt_i          (dcache_rsp_i.data_gnt),
        .data_rvalid_i       (dcache_rsp_i.data_rvalid),
        .drop_rvalid_o       (drop_rvalid)
    );

    // the record is written in the grant cycle, the same cycle as pop
    load_realign i_load_realign (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pop_i    (pop_o),
        .meta_i   (meta),
        .rvalid_i (dcache_rsp_i.data_rvalid),
        .drop_i   (drop_rvalid),
        .rdata_i  (dcache_rsp_i.data_rdata),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_load_unit.sv ====
/* load unit testbench: clock and reset, random loads and flushes, TLB and
   cache responders, result model with compare tasks, watchdog */

`timescale 1ns/1ns
`default_nettype none

module tb_load_unit;

    localparam int unsigned NUM_TESTS  = 64;
    // 40 cycles of 4 ns for every load, plus reset and drain
    localparam int unsigned TIMEOUT_NS = (NUM_TESTS * 40 + 10) * 4;

    logic                               clk_i;
    logic                               rst_ni;
    logic                               flush_i;
    logic                               valid_i;
    load_pkg::load_req_t                req_i;
    logic                               pop_o;
    logic                               translation_req_o;
    logic [load_pkg::VADDR_W-1:0]       vaddr_o;
    logic [load_pkg::PADDR_W-1:0]       paddr_i;
    logic                               dtlb_hit_i;
    logic [load_pkg::PAGE_OFF_W-1:0]    page_offset_o;
    logic                               page_offset_match_i;
    dcache_pkg::dcache_req_t            dcache_req_o;
    dcache_pkg::dcache_rsp_t            dcache_rsp_i;
    logic                               valid_o;
    load_pkg::load_result_t             result_o;

    // expected results in pop order and the cache returns with the cycle they are due in
    load_pkg::load_result_t             exp_q[$];
    logic [63:0]                        ret_q[$];
    int unsigned                        ret_due_q[$];
    dcache_pkg::dcache_req_t            exp_tag_req;
    logic                               expect_tag;
    logic                               expect_kill;
    logic                               gnt_pending;
    logic [dcache_pkg::INDEX_W-1:0]     gnt_index;
    logic                               pop_seen;
    logic                               nxt_gnt;
    logic                               nxt_hit;
    logic                               nxt_rvalid;
    logic [63:0]                        nxt_rdata;
    int unsigned                        cyc;
    int unsigned                        err_count;
    int unsigned                        fail_count;

    load_unit DUT (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .req_i               (req_i),
        .pop_o               (pop_o),
        .translation_req_o   (translation_req_o),
        .vaddr_o             (vaddr_o),
        .paddr_i             (paddr_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .page_offset_o       (page_offset_o),
        .page_offset_match_i (page_offset_match_i),
        .dcache_req_o        (dcache_req_o),
        .dcache_rsp_i        (dcache_rsp_i),
        .valid_o             (valid_o),
        .result_o            (result_o)
    );

    always #2 clk_i = ~clk_i;

    // the TLB maps every page to a fixed scrambled frame while the offset passes through
    assign paddr_i = {17'h1B5E3, vaddr_o[38:12] ^ 27'h55AC3F1, vaddr_o[11:0]};

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [1:0] size_of_op(input load_pkg::load_op_e op);
        case (op)
            load_pkg::LB, load_pkg::LBU: return 2'd0;
            load_pkg::LH, load_pkg::LHU: return 2'd1;
            load_pkg::LW, load_pkg::LWU: return 2'd2;
            default:                     return 2'd3;
        endcase
    endfunction

    // cache contents where every physical address bit changes the word
    function automatic logic [63:0] line_hash(input logic [55:0] pa);
        logic [63:0] h;
        h = {8'h5a, pa} * 64'h9E37_79B9_7F4A_7C15;
        return h ^ (h >> 29) ^ {pa[27:0], pa[55:20]};
    endfunction

    function automatic logic [63:0] extend_load(input load_pkg::load_op_e op,
                                                input logic [2:0] off, input logic [63:0] word);
        logic [63:0] s;
        s = word >> (8 * off);
        case (op)
            load_pkg::LB:  return {{56{s[7]}}, s[7:0]};
            load_pkg::LBU: return {56'h0, s[7:0]};
            load_pkg::LH:  return {{48{s[15]}}, s[15:0]};
            load_pkg::LHU: return {48'h0, s[15:0]};
            load_pkg::LW:  return {{32{s[31]}}, s[31:0]};
            load_pkg::LWU: return {32'h0, s[31:0]};
            default:       return s;
        endcase
    endfunction

    // naturally aligned random load whose byte enables cover the loaded bytes
    function automatic load_pkg::load_req_t random_req(input int unsigned num);
        load_pkg::load_req_t req;
        logic [1:0]          size;
        logic [2:0]          off;
        req.trans_id = num[2:0];
        req.op       = load_pkg::load_op_e'($urandom % 7);
        size         = size_of_op(req.op);
        off          = 3'($urandom);
        off          = (off >> size) << size;
        req.vaddr    = {$urandom, $urandom};
        req.vaddr[2:0] = off;
        req.be       = 8'(((9'h1 << (1 << size)) - 9'h1) << off);
        return req;
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    task automatic report_error(input string msg);
        err_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_result(input load_pkg::load_result_t exp,
                                input load_pkg::load_result_t got);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: result_o exp %h got %h", $time, exp, got);
        end
    endtask

    // with full low only the handshake bits are compared
    task automatic check_req(input dcache_pkg::dcache_req_t exp,
                             input dcache_pkg::dcache_req_t got, input logic full);
        if (full && got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: dcache_req_o exp %h got %h", $time, exp, got);
        end else if (!full && {got.data_req, got.tag_valid, got.kill_req} !==
                              {exp.data_req, exp.tag_valid, exp.kill_req}) begin
            err_count++;
            $display("mismatch at %0t ns: dcache_req_o req,tag,kill exp %b%b%b got %b%b%b",
                     $time, exp.data_req, exp.tag_valid, exp.kill_req,
                     got.data_req, got.tag_valid, got.kill_req);
        end
    endtask

    // the page offset is compared zero extended to the virtual address width
    task automatic check_addr(input string name, input logic [load_pkg::VADDR_W-1:0] exp,
                              input logic [load_pkg::VADDR_W-1:0] got);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: %s exp %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input int unsigned num, input string what,
                               input int unsigned errs_before);
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", num, what);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", num, what, err_count - errs_before);
        end
    endtask

    // ------------------------------
    // monitor, cache and TLB responders
    // ------------------------------
    // everything is sampled at the falling edge, half a cycle after the inputs moved
    always @(negedge clk_i) begin
        load_pkg::load_result_t  exp_res;
        dcache_pkg::dcache_req_t kill_exp;
        int unsigned             due;
        if (rst_ni) begin
            cyc++;
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    report_error("valid_o is high while no load is outstanding");
                end else begin
                    exp_res = exp_q.pop_front();
                    check_result(exp_res, result_o);
                end
            end
            kill_exp           = '0;
            kill_exp.tag_valid = 1'b1;
            kill_exp.kill_req  = 1'b1;
            if (expect_tag) begin
                check_req(exp_tag_req, dcache_req_o, 1'b1);
            end else if (expect_kill) begin
                check_req(kill_exp, dcache_req_o, 1'b0);
            end else if (dcache_req_o.tag_valid || dcache_req_o.kill_req) begin
                report_error("tag phase seen without a pop, a TLB miss or a flush before it");
            end
            if (page_offset_match_i && (dcache_req_o.data_req || pop_o)) begin
                report_error("cache request sent while the page offset still matches a store");
            end
            // the TLB and the store checker see the address of the load on issue
            if (translation_req_o) begin
                check_addr("vaddr_o", req_i.vaddr, vaddr_o);
                check_addr("page_offset_o", req_i.vaddr[11:0], page_offset_o);
            end
            // an index waiting for its grant keeps the translation request up
            if (dcache_req_o.data_req) begin
                check_flag("translation_req_o", 1'b1, translation_req_o);
            end
            // a granted index with a TLB hit pops the load unless a flush holds it back
            check_flag("pop_o", dcache_req_o.data_req && dcache_rsp_i.data_gnt &&
                       dtlb_hit_i && !flush_i, pop_o);
            // what the next cycle has to show in the tag phase
            expect_tag  = pop_o;
            expect_kill = !pop_o && (flush_i || (dcache_req_o.data_req &&
                                     dcache_rsp_i.data_gnt && !dtlb_hit_i));
            if (pop_o) begin
                pop_seen                  = 1'b1;
                exp_tag_req               = '0;
                exp_tag_req.address_index = req_i.vaddr[11:0];
                exp_tag_req.address_tag   = paddr_i[55:12];
                exp_tag_req.data_be       = req_i.be;
                exp_tag_req.data_size     = size_of_op(req_i.op);
                exp_tag_req.tag_valid     = 1'b1;
                exp_res.trans_id          = req_i.trans_id;
                exp_res.result            = extend_load(req_i.op, req_i.vaddr[2:0],
                                                        line_hash({paddr_i[55:12],
                                                                   req_i.vaddr[11:0]}));
                exp_q.push_back(exp_res);
            end
            // a granted index waits for its tag and a killed one is forgotten
            if (dcache_req_o.tag_valid) begin
                if (!dcache_req_o.kill_req && gnt_pending) begin
                    due = cyc + 1 + $urandom % 4;
                    if (ret_due_q.size() != 0 && due <= ret_due_q[$]) begin
                        due = ret_due_q[$] + 1;
                    end
                    ret_q.push_back(line_hash({dcache_req_o.address_tag, gnt_index}));
                    ret_due_q.push_back(due);
                end
                gnt_pending = 1'b0;
            end
            if (dcache_req_o.data_req && dcache_rsp_i.data_gnt) begin
                gnt_pending = 1'b1;
                gnt_index   = dcache_req_o.address_index;
            end
            nxt_rvalid = 1'b0;
            nxt_rdata  = {$urandom, $urandom};
            if (ret_q.size() != 0 && ret_due_q[0] <= cyc + 1) begin
                nxt_rvalid = 1'b1;
                nxt_rdata  = ret_q.pop_front();
                void'(ret_due_q.pop_front());
            end else if (expect_kill) begin
                // stray read data in an abort or flush kill cycle must be dropped
                nxt_rvalid = 1'b1;
            end
            nxt_gnt = ($urandom % 10) < 6;
            nxt_hit = ($urandom % 10) < 7;
        end
    end

    always @(posedge clk_i) begin
        #1;
        dtlb_hit_i               = nxt_hit;
        dcache_rsp_i.data_gnt    = nxt_gnt;
        dcache_rsp_i.data_rvalid = nxt_rvalid;
        dcache_rsp_i.data_rdata  = nxt_rdata;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    // one load at a time with the page offset match held for 0 to 3 cycles
    task automatic run_load(input int unsigned num);
        load_pkg::load_req_t req;
        int unsigned         hold;
        int unsigned         errs_before;
        errs_before = err_count;
        req         = random_req(num);
        hold        = $urandom % 4;
        pop_seen    = 1'b0;
        @(posedge clk_i);
        #1;
        valid_i             = 1'b1;
        req_i               = req;
        page_offset_match_i = (hold > 0);
        while (!pop_seen) begin
            @(posedge clk_i);
            #1;
            if (hold > 0) begin
                hold--;
            end
            page_offset_match_i = (hold > 0);
        end
        valid_i             = 1'b0;
        page_offset_match_i = 1'b0;
        while (exp_q.size() != 0 || ret_q.size() != 0) begin
            @(posedge clk_i);
        end
        report_test(num, $sformatf("%s offset %0d", req.op.name(), req.vaddr[2:0]),
                    errs_before);
    endtask

    // a flush together with a new load keeps the load with issue and nothing returns
    task automatic run_flush(input int unsigned num);
        int unsigned errs_before;
        errs_before = err_count;
        @(posedge clk_i);
        #1;
        valid_i = 1'b1;
        req_i   = random_req(num);
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        flush_i = 1'b0;
        repeat (3) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            report_error("a load was accepted in the flush cycle");
        end
        report_test(num, "flush", errs_before);
    endtask

    initial begin
        int unsigned errs_before;
        void'($urandom(31094));
        clk_i               = 1'b0;
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        valid_i             = 1'b0;
        req_i               = '0;
        dtlb_hit_i          = 1'b0;
        page_offset_match_i = 1'b0;
        dcache_rsp_i        = '0;
        {nxt_gnt, nxt_hit, nxt_rvalid, nxt_rdata} = '0;
        {expect_tag, expect_kill, gnt_pending, pop_seen} = '0;
        exp_tag_req = '0;
        gnt_index   = '0;
        cyc         = 0;
        err_count   = 0;
        fail_count  = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni      = 1'b1;
        errs_before = err_count;
        repeat (2) @(negedge clk_i);
        if (translation_req_o || pop_o || dcache_req_o.data_req || dcache_req_o.tag_valid ||
            dcache_req_o.kill_req || valid_o) begin
            report_error("a control output is high after reset with no load issued");
        end
        report_test(0, "reset", errs_before);
        for (int unsigned i = 1; i <= NUM_TESTS; i++) begin
            if (i % 8 == 0) begin
                run_flush(i);
            end else begin
                run_load(i);
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, fail_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the loads did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/load_pkg.sv
verilog/dcache_pkg.sv
verilog/load_fsm.sv
verilog/load_realign.sv
verilog/load_unit.sv
verif/tb_load_unit.sv

// ==== Bender.yml ====
package:
  name: load_unit

sources:
  - verilog/load_pkg.sv
  - verilog/dcache_pkg.sv
  - verilog/load_fsm.sv
  - verilog/load_realign.sv
  - verilog/load_unit.sv
  - target: test
    files:
      - verif/tb_load_unit.sv
